//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // line and set geometry
    localparam int LEN_OFFSET = 5;
    localparam int LEN_INDEX  = 7;
    localparam int LEN_TAG    = 20;
    localparam int NR_WORDS   = 8;
    localparam int NR_WAYS    = 2;

    typedef logic [31:0]           word_t;
    typedef logic [LEN_TAG-1:0]    tag_t;
    typedef logic [LEN_INDEX-1:0]  index_t;
    typedef logic [LEN_OFFSET-3:0] word_sel_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        word_sel_t  word_sel;
        logic [1:0] byte_sel;
    } fetch_addr_t;

    typedef struct packed {
        fetch_addr_t addr;
        logic        uncached;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    // write port command into tag and data RAMs
    typedef struct packed {
        logic [NR_WAYS-1:0] wr_en;
        index_t             index;
        word_sel_t          word_sel;
        word_t              data;
    } fill_t;

endpackage

`default_nettype wire

//--- src/icache_ram.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ram #(
    parameter type payload_t = logic,
    parameter int  ADDR_W    = 7
) (
    input  wire              clk,
    input  wire              i_wr_en,
    input  wire [ADDR_W-1:0] i_wr_addr,
    input  wire payload_t    i_wr_data,
    input  wire              i_rd_en,
    input  wire [ADDR_W-1:0] i_rd_addr,
    output payload_t         o_rd_data
);

    payload_t mem [2**ADDR_W];

    // read returns old data when both ports hit the same entry
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- src/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             i_miss_start,
    input  wire fetch_req_t i_miss_req,
    input  wire             i_victim,
    output logic            o_refill_done,
    output word_t           o_refill_word,
    output fill_t           o_fill,
    output axi_ar_t         o_ar,
    output logic            o_arvalid,
    input  wire             i_arready,
    input  wire axi_r_t     i_r,
    input  wire             i_rvalid,
    output logic            o_rready
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } state_t;

    state_t     state_q;
    fetch_req_t req_q;
    logic       victim_q;
    word_sel_t  beat_q;
    word_t      word_q;
    logic       start;
    logic       beat;
    logic       pick;

    assign start = (state_q == IDLE) && i_miss_start;
    assign beat  = i_rvalid && o_rready;
    // uncached reads carry only the wanted word
    assign pick  = req_q.uncached || (beat_q == req_q.addr.word_sel);

    assign o_arvalid     = (state_q == ADDR);
    assign o_rready      = (state_q == DATA);
    assign o_refill_done = (state_q == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_miss_start) begin
                        state_q <= ADDR;
                        beat_q  <= '0;
                    end
                end
                ADDR: begin
                    if (i_arready) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (beat) begin
                        beat_q <= beat_q + 1'b1;
                        if (i_r.last) begin
                            state_q <= DONE;
                        end
                    end
                end
                // last fill write lands before done is seen
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q    <= i_miss_req;
            victim_q <= i_victim;
        end
        if (beat && pick) begin
            word_q <= i_r.data;
        end
        if (beat && i_r.last) begin
            o_refill_word <= pick ? i_r.data : word_q;
        end
    end

    always_comb begin
        o_ar.size = 3'd2;
        if (req_q.uncached) begin
            o_ar.addr = {req_q.addr.tag, req_q.addr.index, req_q.addr.word_sel, 2'b00};
            o_ar.len  = 8'd0;
        end else begin
            // whole line from its aligned start
            o_ar.addr = {req_q.addr.tag, req_q.addr.index, {LEN_OFFSET{1'b0}}};
            o_ar.len  = 8'(NR_WORDS - 1);
        end
    end

    always_comb begin
        o_fill.wr_en = '0;
        if (beat && !req_q.uncached) begin
            o_fill.wr_en[victim_q] = 1'b1;
        end
        o_fill.index    = req_q.addr.index;
        o_fill.word_sel = beat_q;
        o_fill.data     = i_r.data;
    end

endmodule

`default_nettype wire

//--- src/icache_core.sv
`timescale 1ns/1ns
`default_nettype none

module icache_core
    import icache_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire fetch_req_t i_req,
    input  wire             i_en,
    input  wire             i_hold,
    output logic            o_stall,
    output word_t           o_rdata,
    output logic            o_miss_start,
    output fetch_req_t      o_miss_req,
    output logic            o_victim,
    input  wire             i_refill_done,
    input  wire word_t      i_refill_word,
    input  wire fill_t      i_fill
);

    fetch_req_t         req_q;
    logic               en_q;
    logic               busy_q;
    logic               show_q;
    tag_t               miss_tag_q;
    logic [NR_WAYS-1:0] valid_q [2**LEN_INDEX];
    // per set, the way that was used least recently
    logic               lru_q [2**LEN_INDEX];

    logic               load;
    logic               active;
    logic [NR_WAYS-1:0] way_hit;
    logic               hit;
    logic               hit_way;
    logic               fill_way;
    tag_t               rd_tag [NR_WAYS];
    word_t              rd_word [NR_WAYS];

    // IF2 also reloads while stalled so the RAM outputs track the fill
    assign load = ~i_hold | o_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= 1'b0;
        end else if (load) begin
            en_q <= i_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= i_req;
        end
        if (o_miss_start) begin
            miss_tag_q <= req_q.addr.tag;
        end
    end

    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        icache_ram #(
            .payload_t (tag_t),
            .ADDR_W    (LEN_INDEX)
        ) u_tag (
            .clk       (clk),
            .i_wr_en   (i_fill.wr_en[w]),
            .i_wr_addr (i_fill.index),
            .i_wr_data (miss_tag_q),
            .i_rd_en   (load),
            .i_rd_addr (i_req.addr.index),
            .o_rd_data (rd_tag[w])
        );

        icache_ram #(
            .payload_t (word_t),
            .ADDR_W    (LEN_INDEX + LEN_OFFSET - 2)
        ) u_data (
            .clk       (clk),
            .i_wr_en   (i_fill.wr_en[w]),
            .i_wr_addr ({i_fill.index, i_fill.word_sel}),
            .i_wr_data (i_fill.data),
            .i_rd_en   (load),
            .i_rd_addr ({i_req.addr.index, i_req.addr.word_sel}),
            .o_rd_data (rd_word[w])
        );

        assign way_hit[w] = valid_q[req_q.addr.index][w] && (rd_tag[w] == req_q.addr.tag);
    end

    assign hit      = (|way_hit) && !req_q.uncached;
    assign hit_way  = way_hit[1];
    assign fill_way = i_fill.wr_en[1];

    // IF2 content is stale while a miss is open or its word is still shown
    assign active = en_q && !busy_q && !show_q;

    assign o_miss_start = active && !hit;
    assign o_miss_req   = req_q;
    assign o_victim     = lru_q[req_q.addr.index];

    always_comb begin
        if (busy_q) begin
            o_stall = !i_refill_done;
        end else begin
            o_stall = active && !hit;
        end
    end

    assign o_rdata = (i_refill_done || show_q) ? i_refill_word : rd_word[hit_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            show_q  <= 1'b0;
            valid_q <= '{default: '0};
            lru_q   <= '{default: 1'b0};
        end else begin
            if (o_miss_start) begin
                busy_q <= 1'b1;
            end else if (i_refill_done) begin
                busy_q <= 1'b0;
            end

            // keep the refill word up while the pipe holds
            if (i_refill_done) begin
                show_q <= i_hold;
            end else begin
                show_q <= show_q && i_hold;
            end

            if (|i_fill.wr_en) begin
                valid_q[i_fill.index][fill_way] <= 1'b1;
                lru_q[i_fill.index]             <= ~fill_way;
            end else if (active && hit && !i_hold) begin
                lru_q[req_q.addr.index] <= ~hit_way;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire fetch_req_t i_req,
    input  wire             i_en,
    input  wire             i_hold,
    output logic            o_stall,
    output word_t           o_rdata,
    output axi_ar_t         o_ar,
    output logic            o_arvalid,
    input  wire             i_arready,
    input  wire axi_r_t     i_r,
    input  wire             i_rvalid,
    output logic            o_rready
);

    logic       miss_start;
    fetch_req_t miss_req;
    logic       victim;
    logic       refill_done;
    word_t      refill_word;
    fill_t      fill;

    icache_core u_core (
        .clk           (clk),
        .rst           (rst),
        .i_req         (i_req),
        .i_en          (i_en),
        .i_hold        (i_hold),
        .o_stall       (o_stall),
        .o_rdata       (o_rdata),
        .o_miss_start  (miss_start),
        .o_miss_req    (miss_req),
        .o_victim      (victim),
        .i_refill_done (refill_done),
        .i_refill_word (refill_word),
        .i_fill        (fill)
    );

    icache_refill u_refill (
        .clk           (clk),
        .rst           (rst),
        .i_miss_start  (miss_start),
        .i_miss_req    (miss_req),
        .i_victim      (victim),
        .o_refill_done (refill_done),
        .o_refill_word (refill_word),
        .o_fill        (fill),
        .o_ar          (o_ar),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_r           (i_r),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready)
    );

endmodule

`default_nettype wire

//--- bench/icache_props.sv
`timescale 1ns/1ns
`default_nettype none

module icache_props
    import icache_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire axi_ar_t i_ar,
    input wire          i_arvalid,
    input wire          i_arready,
    input wire          i_rready,
    input wire          i_refill_done,
    input wire axi_r_t  i_r,
    input wire          i_rvalid
);

    // address must not move until the slave takes it
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
        else $error("AR changed or dropped before its handshake");

    // data phase opens only right after the address handshake
    rready_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(i_rready) |-> $past(i_arvalid && i_arready))
        else $error("rready rose without a preceding AR handshake");

    done_after_last: assert property (@(posedge clk) disable iff (rst)
        i_rvalid && i_rready && i_r.last |=> i_refill_done)
        else $error("refill done did not follow the last beat");

endmodule

bind icache_refill icache_props u_props (
    .clk           (clk),
    .rst           (rst),
    .i_ar          (o_ar),
    .i_arvalid     (o_arvalid),
    .i_arready     (i_arready),
    .i_rready      (o_rready),
    .i_refill_done (o_refill_done),
    .i_r           (i_r),
    .i_rvalid      (i_rvalid)
);

`default_nettype wire

//--- bench/icache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module icache_mem_model
    import icache_pkg::*;
(
    input  wire          clk,
    input  wire axi_ar_t i_ar,
    input  wire          i_arvalid,
    output logic         o_arready,
    output axi_r_t       o_r,
    output logic         o_rvalid,
    input  wire          i_rready,
    output int           o_ar_count,
    output int           o_beat_count,
    output axi_ar_t      o_last_ar
);

    // memory content follows the byte address of each word
    function automatic word_t word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    task automatic wait_gap();
        int gap;
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic serve_read();
        axi_ar_t ar;
        wait_gap();
        ar = i_ar;
        o_last_ar = ar;
        o_ar_count++;
        o_arready = 1'b1;
        @(posedge clk);
        #5;
        o_arready = 1'b0;
        for (int b = 0; b <= int'(ar.len); b++) begin
            wait_gap();
            o_r.data = word_at(ar.addr + 32'(4 * b));
            o_r.last = (b == int'(ar.len));
            o_rvalid = 1'b1;
            while (!i_rready) begin
                @(posedge clk);
                #5;
            end
            @(posedge clk);
            #5;
            o_rvalid = 1'b0;
            o_beat_count++;
        end
    endtask

    initial begin
        o_arready    = 1'b0;
        o_rvalid     = 1'b0;
        o_r          = '0;
        o_ar_count   = 0;
        o_beat_count = 0;
        o_last_ar    = '0;
        forever begin
            @(posedge clk);
            #5;
            if (i_arvalid) begin
                serve_read();
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    logic       clk;
    logic       rst;
    fetch_req_t req;
    logic       en;
    logic       hold;
    logic       stall;
    word_t      rdata;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    int         ar_count;
    int         beat_count;
    axi_ar_t    last_ar;

    word_t      addr_q [$];
    logic       unc_q [$];
    logic       hit_q [$];

    icache_top UUT (
        .clk       (clk),
        .rst       (rst),
        .i_req     (req),
        .i_en      (en),
        .i_hold    (hold),
        .o_stall   (stall),
        .o_rdata   (rdata),
        .o_ar      (ar),
        .o_arvalid (arvalid),
        .i_arready (arready),
        .i_r       (r),
        .i_rvalid  (rvalid),
        .o_rready  (rready)
    );

    icache_mem_model u_mem (
        .clk          (clk),
        .i_ar         (ar),
        .i_arvalid    (arvalid),
        .o_arready    (arready),
        .o_r          (r),
        .o_rvalid     (rvalid),
        .i_rready     (rready),
        .o_ar_count   (ar_count),
        .o_beat_count (beat_count),
        .o_last_ar    (last_ar)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t rule_word(input word_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            report_failure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("** Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
        string exp_s;
        string act_s;
        exp_s = $sformatf("addr %h len %0d size %0d", exp.addr, exp.len, exp.size);
        act_s = $sformatf("addr %h len %0d size %0d", act.addr, act.len, act.size);
        if (exp !== act) begin
            report_failure($sformatf("** Error: %s expected %s actual %s", name, exp_s, act_s));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            report_failure($sformatf("** Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic load_fetches();
        int    fd;
        int    unc;
        int    hit;
        word_t addr;
        string line;
        fd = $fopen("bench/icache_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/icache_input.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %d %d", addr, unc, hit) == 3) begin
                        addr_q.push_back(addr);
                        unc_q.push_back(unc != 0);
                        hit_q.push_back(hit != 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_fetch(input int i);
        fetch_req_t f;
        word_t      addr;
        logic       exp_hit;
        int         n_hold;
        int         ar_before;
        int         beats_before;
        axi_ar_t    exp_ar;
        string      name;
        addr       = addr_q[i];
        exp_hit    = hit_q[i];
        name       = $sformatf("fetch %0d at %h", i, addr);
        f.addr     = addr;
        f.uncached = unc_q[i];
        // freeze only hits, for 0 to 3 extra cycles
        n_hold       = exp_hit ? int'($urandom_range(3, 0)) : 0;
        ar_before    = ar_count;
        beats_before = beat_count;

        @(posedge clk);
        #5;
        req  = f;
        en   = 1'b1;
        hold = 1'b0;
        @(posedge clk);
        #5;
        en   = 1'b0;
        hold = (n_hold != 0);
        @(negedge clk);
        check_hit({name, " hit"}, exp_hit, !stall);

        if (stall) begin
            while (stall) begin
                @(negedge clk);
            end
            exp_ar.size = 3'd2;
            if (f.uncached) begin
                exp_ar.addr = {addr[31:2], 2'b00};
                exp_ar.len  = 8'd0;
            end else begin
                exp_ar.addr = {addr[31:5], 5'b00000};
                exp_ar.len  = 8'd7;
            end
            check_count({name, " reads"}, 1, ar_count - ar_before);
            check_ar({name, " read address"}, exp_ar, last_ar);
            check_count({name, " beats"}, int'(exp_ar.len) + 1, beat_count - beats_before);
        end else begin
            check_count({name, " reads"}, 0, ar_count - ar_before);
        end
        check_word(name, rule_word(addr), rdata);

        repeat (n_hold) begin
            @(negedge clk);
            check_word({name, " held"}, rule_word(addr), rdata);
        end
    endtask

    initial begin
        void'($urandom(44));
        rst  = 1'b1;
        en   = 1'b0;
        hold = 1'b0;
        req  = '0;
        load_fetches();

        // about 60 cycles per fetch covers the slowest bus gaps
        fork
            begin
                repeat (addr_q.size() * 60 + 8) @(posedge clk);
                report_failure("timeout: the fetch sequence did not finish in time");
            end
        join_none

        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int i = 0; i < addr_q.size(); i++) begin
            run_fetch(i);
        end
        @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/icache_pkg.sv
src/icache_ram.sv
src/icache_refill.sv
src/icache_core.sv
src/icache_top.sv
bench/icache_props.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

TOP     ?= icache_tb
SEED    ?= 44
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables:"
	@echo "  TOP=$(TOP) SEED=$(SEED) OBJ_DIR=$(OBJ_DIR)"
	@echo "  VFLAGS=$(VFLAGS)"

test:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/icache_input.txt
# columns: fetch byte address (hex), uncached flag, expected hit flag
# hit flags follow the two-way LRU rule
00001000 0 0
00001008 0 1
0000101c 0 1
00002034 0 0
00002020 0 1
0000203c 0 1
00010060 0 0
00020060 0 0
00010064 0 1
00030060 0 0
00010068 0 1
00020060 0 0
00030060 0 0
0002006c 0 1
00030070 0 1
00010060 0 0
00004010 1 0
00004010 1 0
00004010 0 0
00004014 0 1
00001010 0 1
00005000 0 0
00001004 0 1
00004018 0 0
